// File: armPkg.sv
`default_nettype none

package armPkg;

  localparam int dataWidth = 32;
  localparam int regCount = 16;
  localparam logic [31:0] resetPc = 32'h0000_0000;

  // Data-processing opcodes, instruction bits 24:21
  localparam logic [3:0] opAnd = 4'b0000;
  localparam logic [3:0] opSub = 4'b0010;
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opCmp = 4'b1010;
  localparam logic [3:0] opOrr = 4'b1100;
  localparam logic [3:0] opMov = 4'b1101;

  // SWI AL, which the control unit treats as a bubble
  localparam logic [31:0] nopInstr = 32'hEF00_0000;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluOpT;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl
  } condT;

  typedef struct packed {
    logic  regWrite;
    logic  memWrite;
    logic  memToReg;
    logic  aluSrcImm;
    logic  flagWrite;
    logic  branch;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT        ctrl;
    condT        cond;
    logic [3:0]  rd;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] storeData;
    logic [31:0] imm;
    logic [31:0] pcPlus8;
  } deStageT;

  typedef struct packed {
    logic        regWrite;
    logic        memWrite;
    logic        memToReg;
    logic [3:0]  rd;
    logic [31:0] aluOut;
    logic [31:0] storeData;
  } emStageT;

  typedef struct packed {
    logic        regWrite;
    logic        memToReg;
    logic [3:0]  rd;
    logic [31:0] aluOut;
    logic [31:0] readData;
  } mwStageT;

endpackage

`default_nettype wire

// File: ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded fields of the instruction sitting in the fetch/decode register
interface ctrlIf;

  armPkg::ctrlT ctrl;
  armPkg::condT cond;
  logic [3:0]   rd;
  logic [3:0]   rn;
  logic [3:0]   rm;
  // Memory class uses the 12-bit offset instead of imm8
  logic         useImm12;

  modport ctl (
    output ctrl, cond, rd, rn, rm, useImm12
  );

  modport dp (
    input ctrl, cond, rd, rn, rm, useImm12
  );

endinterface

`default_nettype wire

// File: pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // All-zero payload is a bubble, no control bit set
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           branchTaken,
  input  logic [armPkg::dataWidth-1:0]   branchTarget,
  input  logic [armPkg::dataWidth-1:0]   instruction,
  output logic [armPkg::dataWidth-1:0]   pc,
  output logic [armPkg::dataWidth-1:0]   instrD,
  output logic [armPkg::dataWidth-1:0]   pcPlus8D
);

  logic [armPkg::dataWidth-1:0] pcNext;

  // Redirect wins over sequential fetch
  assign pcNext = branchTaken ? branchTarget : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= armPkg::resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk) begin
    if (rst || branchTaken) begin
      instrD <= armPkg::nopInstr;
    end else begin
      instrD <= instruction;
    end
    pcPlus8D <= pc + 32'd8;
  end

  pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input logic [armPkg::dataWidth-1:0] instrD,
  ctrlIf.ctl                          ctl
);

  armPkg::ctrlT ctrlNext;
  logic         dpShapeOk;
  logic         memClass;

  // No shift on register operands and no rotation on imm8
  assign dpShapeOk = instrD[25] ? (instrD[11:8] == 4'b0000) : (instrD[11:4] == 8'h00);
  assign memClass = (instrD[27:26] == 2'b01);

  always_comb begin
    ctrlNext = '0;
    case (instrD[27:26])
      2'b00: begin
        if (dpShapeOk) begin
          ctrlNext.regWrite = 1'b1;
          ctrlNext.aluSrcImm = instrD[25];
          ctrlNext.flagWrite = instrD[20];
          case (instrD[24:21])
            armPkg::opAdd: ctrlNext.aluOp = armPkg::aluAdd;
            armPkg::opSub: ctrlNext.aluOp = armPkg::aluSub;
            armPkg::opAnd: ctrlNext.aluOp = armPkg::aluAnd;
            armPkg::opOrr: ctrlNext.aluOp = armPkg::aluOrr;
            armPkg::opMov: ctrlNext.aluOp = armPkg::aluPassB;
            armPkg::opCmp: begin
              // Subtract for flags only
              ctrlNext.aluOp = armPkg::aluSub;
              ctrlNext.regWrite = 1'b0;
              ctrlNext.flagWrite = 1'b1;
            end
            default: ctrlNext = '0;
          endcase
        end
      end
      2'b01: begin
        // Only immediate offset, pre-indexed, up, word, no writeback
        if (instrD[25:21] == 5'b01100) begin
          ctrlNext.aluSrcImm = 1'b1;
          ctrlNext.aluOp = armPkg::aluAdd;
          ctrlNext.regWrite = instrD[20];
          ctrlNext.memToReg = instrD[20];
          ctrlNext.memWrite = !instrD[20];
        end
      end
      2'b10: begin
        // B only, BL is left out
        if (instrD[25:24] == 2'b10) begin
          ctrlNext.branch = 1'b1;
        end
      end
      default: ctrlNext = '0;
    endcase
    // NV condition has no meaning here
    if (instrD[31:28] == 4'hF) begin
      ctrlNext = '0;
    end
  end

  assign ctl.ctrl = ctrlNext;
  assign ctl.cond = armPkg::condT'(instrD[31:28]);
  // Rd doubles as the store data source for STR
  assign ctl.rd = instrD[15:12];
  assign ctl.rn = instrD[19:16];
  assign ctl.rm = instrD[3:0];
  assign ctl.useImm12 = memClass;

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush,
  input  logic                         wbWrite,
  input  logic [armPkg::dataWidth-1:0] instrD,
  input  logic [armPkg::dataWidth-1:0] pcPlus8D,
  input  logic [armPkg::dataWidth-1:0] wbData,
  input  logic [3:0]                   wbRd,
  ctrlIf.dp                            dp,
  output armPkg::deStageT              de
);

  logic [armPkg::dataWidth-1:0] regFile [armPkg::regCount];
  logic [armPkg::dataWidth-1:0] immExt;
  armPkg::deStageT              deNext;

  always_ff @(posedge clk) begin
    if (wbWrite) begin
      regFile[wbRd] <= wbData;
    end
  end

  // R15 reads as own address plus 8, otherwise write-through from writeback
  function automatic logic [armPkg::dataWidth-1:0] readReg(input logic [3:0] addr);
    if (addr == 4'd15) begin
      return pcPlus8D;
    end else if (wbWrite && (wbRd == addr)) begin
      return wbData;
    end else begin
      return regFile[addr];
    end
  endfunction

  always_comb begin
    if (dp.ctrl.branch) begin
      // Word offset to byte offset
      immExt = {{6{instrD[23]}}, instrD[23:0], 2'b00};
    end else if (dp.useImm12) begin
      immExt = {20'h00000, instrD[11:0]};
    end else begin
      immExt = {24'h000000, instrD[7:0]};
    end
  end

  always_comb begin
    deNext.ctrl = dp.ctrl;
    deNext.cond = dp.cond;
    deNext.rd = dp.rd;
    deNext.opA = readReg(dp.rn);
    deNext.opB = readReg(dp.rm);
    deNext.storeData = readReg(dp.rd);
    deNext.imm = immExt;
    deNext.pcPlus8 = pcPlus8D;
  end

  // Decode/execute register, flushed by a taken branch
  pipeReg #(
    .payloadT(armPkg::deStageT)
  ) deReg (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .d(deNext),
    .q(de)
  );

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                         clk,
  input  logic                         rst,
  input  armPkg::deStageT              de,
  output armPkg::emStageT              em,
  output logic                         branchTaken,
  output logic [armPkg::dataWidth-1:0] branchTarget
);

  logic [armPkg::dataWidth-1:0] srcB;
  logic [armPkg::dataWidth-1:0] aluOut;
  logic [armPkg::dataWidth:0]   sum;
  // NZCV
  logic [3:0]                   flags;
  logic [3:0]                   aluFlags;
  logic                         carry;
  logic                         overflow;
  logic                         condPass;
  armPkg::emStageT              emNext;

  assign srcB = de.ctrl.aluSrcImm ? de.imm : de.opB;

  always_comb begin
    sum = '0;
    // Logic ops keep C and V
    carry = flags[1];
    overflow = flags[0];
    case (de.ctrl.aluOp)
      armPkg::aluAdd: begin
        sum = {1'b0, de.opA} + {1'b0, srcB};
        aluOut = sum[31:0];
        carry = sum[32];
        overflow = (de.opA[31] == srcB[31]) && (aluOut[31] != de.opA[31]);
      end
      armPkg::aluSub: begin
        // Carry set means no borrow
        sum = {1'b0, de.opA} + {1'b0, ~srcB} + 33'd1;
        aluOut = sum[31:0];
        carry = sum[32];
        overflow = (de.opA[31] != srcB[31]) && (aluOut[31] != de.opA[31]);
      end
      armPkg::aluAnd: aluOut = de.opA & srcB;
      armPkg::aluOrr: aluOut = de.opA | srcB;
      default: aluOut = srcB;
    endcase
    aluFlags = {aluOut[31], aluOut == 32'd0, carry, overflow};
  end

  function automatic logic condCheck(input armPkg::condT cond, input logic [3:0] nzcv);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = nzcv;
    case (cond)
      armPkg::condEq: return z;
      armPkg::condNe: return !z;
      armPkg::condCs: return c;
      armPkg::condCc: return !c;
      armPkg::condMi: return n;
      armPkg::condPl: return !n;
      armPkg::condVs: return v;
      armPkg::condVc: return !v;
      armPkg::condHi: return c && !z;
      armPkg::condLs: return !c || z;
      armPkg::condGe: return n == v;
      armPkg::condLt: return n != v;
      armPkg::condGt: return !z && (n == v);
      armPkg::condLe: return z || (n != v);
      armPkg::condAl: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign condPass = condCheck(de.cond, flags);

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= 4'b0000;
    end else if (condPass && de.ctrl.flagWrite) begin
      flags <= aluFlags;
    end
  end

  assign branchTaken = condPass && de.ctrl.branch;
  assign branchTarget = de.pcPlus8 + de.imm;

  // Failed condition turns the instruction into a bubble
  always_comb begin
    emNext.regWrite = de.ctrl.regWrite && condPass;
    emNext.memWrite = de.ctrl.memWrite && condPass;
    emNext.memToReg = de.ctrl.memToReg;
    emNext.rd = de.rd;
    emNext.aluOut = aluOut;
    emNext.storeData = de.storeData;
  end

  pipeReg #(
    .payloadT(armPkg::emStageT)
  ) emReg (
    .clk(clk),
    .rst(rst),
    .flush(1'b0),
    .d(emNext),
    .q(em)
  );

  // Neither instruction flushed by a taken branch may reach memory as a store
  branchNoStore: assert property (@(posedge clk) disable iff (rst)
    ($past(branchTaken, 2) || $past(branchTaken, 3)) |-> !em.memWrite);

endmodule

`default_nettype wire

// File: memAccessStage.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessStage (
  input  logic                         clk,
  input  logic                         rst,
  input  armPkg::emStageT              em,
  input  logic [armPkg::dataWidth-1:0] readData,
  output logic [armPkg::dataWidth-1:0] aluResult,
  output logic [armPkg::dataWidth-1:0] writeData,
  output logic                         writeEnable,
  output logic                         wbWrite,
  output logic [3:0]                   wbRd,
  output logic [armPkg::dataWidth-1:0] wbData
);

  armPkg::mwStageT mwNext;
  armPkg::mwStageT mw;

  // Data memory port
  assign aluResult = em.aluOut;
  assign writeData = em.storeData;
  assign writeEnable = em.memWrite;

  always_comb begin
    mwNext.regWrite = em.regWrite;
    mwNext.memToReg = em.memToReg;
    mwNext.rd = em.rd;
    mwNext.aluOut = em.aluOut;
    mwNext.readData = readData;
  end

  pipeReg #(
    .payloadT(armPkg::mwStageT)
  ) mwReg (
    .clk(clk),
    .rst(rst),
    .flush(1'b0),
    .d(mwNext),
    .q(mw)
  );

  // Writeback result select
  assign wbWrite = mw.regWrite;
  assign wbRd = mw.rd;
  assign wbData = mw.memToReg ? mw.readData : mw.aluOut;

  storeNotLoad: assert property (@(posedge clk) disable iff (rst)
    writeEnable |=> !mw.memToReg);

endmodule

`default_nettype wire

// File: armPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module armPipeline (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [armPkg::dataWidth-1:0] instruction,
  input  logic [armPkg::dataWidth-1:0] readData,
  output logic [armPkg::dataWidth-1:0] pc,
  output logic [armPkg::dataWidth-1:0] aluResult,
  output logic [armPkg::dataWidth-1:0] writeData,
  output logic                         writeEnable
);

  logic                         branchTaken;
  logic [armPkg::dataWidth-1:0] branchTarget;
  logic [armPkg::dataWidth-1:0] instrD;
  logic [armPkg::dataWidth-1:0] pcPlus8D;
  logic                         wbWrite;
  logic [3:0]                   wbRd;
  logic [armPkg::dataWidth-1:0] wbData;
  armPkg::deStageT              de;
  armPkg::emStageT              em;

  ctrlIf ctrlBus ();

  fetchStage stageFetch (
    .clk(clk),
    .rst(rst),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .instruction(instruction),
    .pc(pc),
    .instrD(instrD),
    .pcPlus8D(pcPlus8D)
  );

  controlUnit control (
    .instrD(instrD),
    .ctl(ctrlBus.ctl)
  );

  // Taken branch also flushes decode/execute
  decodeStage stageDecode (
    .clk(clk),
    .rst(rst),
    .flush(branchTaken),
    .wbWrite(wbWrite),
    .instrD(instrD),
    .pcPlus8D(pcPlus8D),
    .wbData(wbData),
    .wbRd(wbRd),
    .dp(ctrlBus.dp),
    .de(de)
  );

  executeStage stageExecute (
    .clk(clk),
    .rst(rst),
    .de(de),
    .em(em),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget)
  );

  memAccessStage stageMem (
    .clk(clk),
    .rst(rst),
    .em(em),
    .readData(readData),
    .aluResult(aluResult),
    .writeData(writeData),
    .writeEnable(writeEnable),
    .wbWrite(wbWrite),
    .wbRd(wbRd),
    .wbData(wbData)
  );

endmodule

`default_nettype wire

// File: tb_armPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_armPipeline;

  localparam int progSize = 64;
  localparam int memWords = 64;
  localparam int settleCycles = 10;
  // MOV R0, R0
  localparam logic [31:0] nopWord = 32'hE1A0_0000;
  // Preloaded word read back by the LDR, byte address 0x80
  localparam int loadIndex = 32;
  localparam logic [31:0] loadValue = 32'hCAFE_1234;

  // Condition field values
  localparam logic [3:0] cEq = 4'h0;
  localparam logic [3:0] cNe = 4'h1;
  localparam logic [3:0] cCs = 4'h2;
  localparam logic [3:0] cCc = 4'h3;
  localparam logic [3:0] cMi = 4'h4;
  localparam logic [3:0] cHi = 4'h8;
  localparam logic [3:0] cLs = 4'h9;
  localparam logic [3:0] cGe = 4'hA;
  localparam logic [3:0] cLt = 4'hB;
  localparam logic [3:0] cGt = 4'hC;
  localparam logic [3:0] cLe = 4'hD;
  localparam logic [3:0] cAl = 4'hE;

  // Data-processing opcodes
  localparam logic [3:0] oAnd = 4'h0;
  localparam logic [3:0] oSub = 4'h2;
  localparam logic [3:0] oAdd = 4'h4;
  localparam logic [3:0] oCmp = 4'hA;
  localparam logic [3:0] oOrr = 4'hC;
  localparam logic [3:0] oMov = 4'hD;

  logic        clk;
  logic        rst;
  logic [31:0] instruction;
  logic [31:0] readData;
  logic [31:0] pc;
  logic [31:0] aluResult;
  logic [31:0] writeData;
  logic        writeEnable;

  logic [31:0] progMem [progSize];
  logic [31:0] dataMem [memWords];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          progLen = 0;
  int          storesSeen = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  armPipeline dut (
    .clk(clk),
    .rst(rst),
    .instruction(instruction),
    .readData(readData),
    .pc(pc),
    .aluResult(aluResult),
    .writeData(writeData),
    .writeEnable(writeEnable)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Instruction memory, combinational on pc
  always_comb begin
    if (pc < 32'(progSize * 4)) begin
      instruction = progMem[pc[7:2]];
    end else begin
      instruction = nopWord;
    end
  end

  assign readData = dataMem[aluResult[7:2]];

  always @(posedge clk) begin
    if (!rst && writeEnable) begin
      dataMem[aluResult[7:2]] <= writeData;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, only %0d of %0d expected stores seen",
               cycleCount, storesSeen, expAddr.size());
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] op,
                                        input logic s, input logic [3:0] rn,
                                        input logic [3:0] rd, input logic [7:0] imm);
    return {cond, 2'b00, 1'b1, op, s, rn, rd, 4'h0, imm};
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] op,
                                        input logic s, input logic [3:0] rn,
                                        input logic [3:0] rd, input logic [3:0] rm);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, up, word, no writeback
  function automatic logic [31:0] memWord(input logic [3:0] cond, input logic load,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [11:0] off);
    return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [23:0] off);
    return {cond, 3'b101, 1'b0, off};
  endfunction

  task automatic emit(input logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fillMemory();
    for (int i = 0; i < memWords; i++) begin
      if (i == loadIndex) begin
        dataMem[i] = loadValue;
      end else begin
        dataMem[i] = $urandom();
      end
    end
  endtask

  // Two instructions always separate a register write from its first read
  task automatic loadProgram();
    for (int i = 0; i < progSize; i++) begin
      progMem[i] = nopWord;
    end
    emit(dpImm(cAl, oMov, 1'b0, 4'd0, 4'd1, 8'h40));
    emit(dpImm(cAl, oMov, 1'b0, 4'd0, 4'd2, 8'h5A));
    emit(dpImm(cAl, oMov, 1'b0, 4'd0, 4'd3, 8'h0F));
    emit(nopWord);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd2, 12'h000));
    expectStore(32'h40, 32'h5A);
    // Immediate and register forms of each operation
    emit(dpReg(cAl, oAdd, 1'b0, 4'd2, 4'd4, 4'd3));
    emit(dpImm(cAl, oSub, 1'b0, 4'd2, 4'd5, 8'h10));
    emit(dpReg(cAl, oAnd, 1'b0, 4'd2, 4'd6, 4'd3));
    emit(dpImm(cAl, oOrr, 1'b0, 4'd2, 4'd7, 8'hA0));
    emit(dpImm(cAl, oAdd, 1'b0, 4'd2, 4'd8, 8'h26));
    emit(dpImm(cAl, oAnd, 1'b0, 4'd2, 4'd9, 8'h33));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd4, 12'h004));
    expectStore(32'h44, 32'h69);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd5, 12'h008));
    expectStore(32'h48, 32'h4A);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd6, 12'h00C));
    expectStore(32'h4C, 32'h0A);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd7, 12'h010));
    expectStore(32'h50, 32'hFA);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd8, 12'h014));
    expectStore(32'h54, 32'h80);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd9, 12'h018));
    expectStore(32'h58, 32'h12);
    emit(dpReg(cAl, oMov, 1'b0, 4'd0, 4'd10, 4'd3));
    emit(dpReg(cAl, oSub, 1'b0, 4'd3, 4'd11, 4'd2));
    emit(dpReg(cAl, oOrr, 1'b0, 4'd2, 4'd12, 4'd3));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd10, 12'h01C));
    expectStore(32'h5C, 32'h0F);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd11, 12'h020));
    expectStore(32'h60, 32'hFFFF_FFB5);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd12, 12'h024));
    expectStore(32'h64, 32'h5F);
    // Load from 0x80, then R15 reads at word 24 and word 25
    emit(memWord(cAl, 1'b1, 4'd1, 4'd4, 12'h040));
    emit(dpImm(cAl, oAdd, 1'b0, 4'd15, 4'd5, 8'h00));
    emit(dpReg(cAl, oMov, 1'b0, 4'd0, 4'd6, 4'd15));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd4, 12'h028));
    expectStore(32'h68, loadValue);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd5, 12'h02C));
    expectStore(32'h6C, 32'h68);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd6, 12'h030));
    expectStore(32'h70, 32'h6C);
    // 0x5A minus 0x0F gives N0 Z0 C1 V0
    emit(dpReg(cAl, oCmp, 1'b1, 4'd2, 4'd0, 4'd3));
    emit(memWord(cEq, 1'b0, 4'd1, 4'd2, 12'h034));
    emit(memWord(cNe, 1'b0, 4'd1, 4'd3, 12'h034));
    expectStore(32'h74, 32'h0F);
    emit(memWord(cGt, 1'b0, 4'd1, 4'd2, 12'h038));
    expectStore(32'h78, 32'h5A);
    emit(memWord(cLt, 1'b0, 4'd1, 4'd3, 12'h038));
    emit(memWord(cLs, 1'b0, 4'd1, 4'd3, 12'h03C));
    emit(memWord(cHi, 1'b0, 4'd1, 4'd12, 12'h03C));
    expectStore(32'h7C, 32'h5F);
    // 0x0F minus 0x5A gives N1 Z0 C0 V0
    emit(dpReg(cAl, oCmp, 1'b1, 4'd3, 4'd0, 4'd2));
    emit(memWord(cGe, 1'b0, 4'd1, 4'd2, 12'h044));
    emit(memWord(cLt, 1'b0, 4'd1, 4'd11, 12'h044));
    expectStore(32'h84, 32'hFFFF_FFB5);
    emit(memWord(cMi, 1'b0, 4'd1, 4'd12, 12'h048));
    expectStore(32'h88, 32'h5F);
    emit(memWord(cCs, 1'b0, 4'd1, 4'd2, 12'h048));
    emit(memWord(cCc, 1'b0, 4'd1, 4'd3, 12'h04C));
    expectStore(32'h8C, 32'h0F);
    // Equal compare, N0 Z1 C1 V0
    emit(dpImm(cAl, oCmp, 1'b1, 4'd3, 4'd0, 8'h0F));
    emit(dpImm(cEq, oMov, 1'b0, 4'd0, 4'd13, 8'h77));
    emit(dpImm(cNe, oMov, 1'b0, 4'd0, 4'd13, 8'h88));
    emit(memWord(cGt, 1'b0, 4'd1, 4'd2, 12'h050));
    emit(memWord(cLe, 1'b0, 4'd1, 4'd3, 12'h050));
    expectStore(32'h90, 32'h0F);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd13, 12'h054));
    expectStore(32'h94, 32'h77);
    // Not-taken BNE falls through
    emit(branchWord(cNe, 24'd4));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd2, 12'h058));
    expectStore(32'h98, 32'h5A);
    // Taken B from word 50 to word 54
    emit(branchWord(cAl, 24'd2));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd3, 12'h05C));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd3, 12'h060));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd3, 12'h064));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd12, 12'h068));
    expectStore(32'hA8, 32'h5F);
    // ADDS wraps to zero with carry out, BCS taken to word 59
    emit(dpImm(cAl, oAdd, 1'b1, 4'd11, 4'd7, 8'h4B));
    emit(branchWord(cCs, 24'd1));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd2, 12'h06C));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd2, 12'h070));
    emit(memWord(cAl, 1'b0, 4'd1, 4'd7, 12'h074));
    expectStore(32'hB4, 32'h0000_0000);
    emit(memWord(cAl, 1'b0, 4'd1, 4'd4, 12'h078));
    expectStore(32'hB8, loadValue);
  endtask

  initial begin
    void'($urandom(50));
    rst = 1'b1;
    loadProgram();
    fillMemory();
    cycleLimit = 2 * progLen + 20;
    // Reset for three cycles, pc parked at zero and no stores
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      checkValue("pc", 32'h0, pc);
      checkValue("writeEnable", 32'h0, {31'h0, writeEnable});
    end
    @(negedge clk);
    checkValue("pc", 32'h4, pc);
    for (int i = 0; i < expAddr.size(); i++) begin
      while (writeEnable !== 1'b1) begin
        @(negedge clk);
      end
      checkValue("aluResult", expAddr[i], aluResult);
      checkValue("writeData", expData[i], writeData);
      storesSeen = i + 1;
      @(negedge clk);
    end
    // Nothing may be stored once the table is exhausted
    for (int i = 0; i < settleCycles; i++) begin
      assert (writeEnable === 1'b0) else begin
        $display("Store after the last expected one, to address %h at %0t", aluResult, $time);
        $display("STATUS: FAIL");
        $fatal(1, "unexpected store");
      end
      @(negedge clk);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: armPipeline.f
armPkg.sv
ctrlIf.sv
pipeReg.sv
fetchStage.sv
controlUnit.sv
decodeStage.sv
executeStage.sv
memAccessStage.sv
armPipeline.sv
tb_armPipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert \
  -f armPipeline.f \
  --top-module tb_armPipeline \
  -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with exit status $status"
  exit $status
fi

exit 0
